// File: all.f
design/deser_pkg.sv
design/flit_counter.sv
design/slice_lane.sv
design/pop_assembler.sv
design/flow_deserializer.sv
bench/flow_deserializer_assertions.sv
bench/tb_flow_deserializer.sv

// File: bench/flow_deserializer_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module flow_deserializer_assertions (
  input wire logic                 clk,
  input wire logic                 rst,
  input wire logic                 push_valid,
  input wire logic                 pop_ready,
  input wire logic                 pop_valid,
  input wire deser_pkg::pop_word_t pop_data,
  input wire logic                 pop_last,
  input wire deser_pkg::flit_id_t  pop_empty_count,
  input wire deser_pkg::meta_t     pop_metadata,
  input wire deser_pkg::flit_id_t  flit_id
);

  import deser_pkg::*;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // A word only exists while its final flit sits on the push side
  a_pop_needs_push: assert property (@(posedge clk) disable iff (rst)
    pop_valid |-> push_valid)
    else $error("pop_valid is high while push_valid is low");

  // A stalled word stays put until the sink takes it
  a_pop_stable: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data) && $stable(pop_last) &&
    $stable(pop_empty_count) && $stable(pop_metadata))
    else $error("pop outputs changed while the word was stalled");

  // ----------------------------------------
  // Pop word contents
  // ----------------------------------------

  // Full words never report empty slices
  a_full_no_empty: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_last |-> pop_empty_count == '0)
    else $error("non final word reports empty slices");

  // Without push_last the word can only close on the last slice
  a_full_index: assert property (@(posedge clk) disable iff (rst)
    pop_valid && !pop_last |-> flit_id == last_flit_id)
    else $error("word offered before the last slice was reached");

endmodule

bind flow_deserializer flow_deserializer_assertions u_assertions (
  .clk             (clk),
  .rst             (rst),
  .push_valid      (push_valid),
  .pop_ready       (pop_ready),
  .pop_valid       (pop_valid),
  .pop_data        (pop_data),
  .pop_last        (pop_last),
  .pop_empty_count (pop_empty_count),
  .pop_metadata    (pop_metadata),
  .flit_id         (flit_id)
);

`default_nettype wire

// File: bench/tb_flow_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_flow_deserializer;

  import deser_pkg::*;

  localparam int num_rows   = 9;
  localparam int wait_limit = 50;

  logic       clk;
  logic       rst;
  logic       push_ready;
  logic       push_valid;
  push_flit_t push_data;
  logic       push_last;
  meta_t      push_metadata;
  logic       pop_ready;
  logic       pop_valid;
  pop_word_t  pop_data;
  logic       pop_last;
  flit_id_t   pop_empty_count;
  meta_t      pop_metadata;

  // Each table row holds the packet length, the first metadata, the stall enable
  // and the empty count expected on the closing word
  int       row_len   [num_rows];
  meta_t    row_meta  [num_rows];
  logic     row_stall [num_rows];
  flit_id_t row_empty [num_rows];

  // The reference model queues one entry for each expected pop word
  pop_word_t exp_data_q  [$];
  logic      exp_last_q  [$];
  flit_id_t  exp_empty_q [$];
  meta_t     exp_meta_q  [$];

  logic [15:0] lfsr_state;
  logic        stall_en;
  logic        timed_out;
  int          row;
  int          word_num;
  int          err_word;
  int          err_count;
  int          err_meta;
  int          err_flag;
  int          err_other;
  int          err_total;

  flow_deserializer uut (
    .clk             (clk),
    .rst             (rst),
    .push_ready      (push_ready),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .push_last       (push_last),
    .push_metadata   (push_metadata),
    .pop_ready       (pop_ready),
    .pop_valid       (pop_valid),
    .pop_data        (pop_data),
    .pop_last        (pop_last),
    .pop_empty_count (pop_empty_count),
    .pop_metadata    (pop_metadata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_word(input string name, input pop_word_t exp, input pop_word_t act);
    if (act !== exp) begin
      err_word++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input flit_id_t exp, input flit_id_t act);
    if (act !== exp) begin
      err_count++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_meta(input string name, input meta_t exp, input meta_t act);
    if (act !== exp) begin
      err_meta++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // ----------------------------------------
  // Random source
  // ----------------------------------------

  // Taps 16, 14, 13 and 11 give a maximal length sequence
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic push_flit_t random_byte();
    push_flit_t b;
    b = '0;
    for (int i = 0; i < push_width; i++) begin
      b = {b[push_width-2:0], next_random_bit()};
    end
    return b;
  endfunction

  // With stalls enabled the sink is ready about three cycles in four
  function automatic logic pick_pop_ready();
    logic a;
    logic b;
    logic ready;
    ready = 1'b1;
    if (stall_en) begin
      a = next_random_bit();
      b = next_random_bit();
      ready = a | b;
    end
    return ready;
  endfunction

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic set_row(input int r, input int len, input meta_t meta, input logic stall,
                         input flit_id_t empty);
    row_len[r]   = len;
    row_meta[r]  = meta;
    row_stall[r] = stall;
    row_empty[r] = empty;
  endtask

  task automatic load_table();
    set_row(0, 4, 3'd5, 1'b0, 2'd0);
    set_row(1, 9, 3'd2, 1'b0, 2'd3);
    set_row(2, 1, 3'd1, 1'b0, 2'd3);
    set_row(3, 2, 3'd3, 1'b0, 2'd2);
    set_row(4, 3, 3'd6, 1'b0, 2'd1);
    set_row(5, 7, 3'd4, 1'b1, 2'd1);
    set_row(6, 9, 3'd0, 1'b1, 2'd3);
    set_row(7, 5, 3'd7, 1'b1, 2'd3);
    set_row(8, 8, 3'd2, 1'b1, 2'd0);
  endtask

  // Called at the negedge before the edge on which the word transfers
  task automatic compare_pop(input string name);
    if (exp_data_q.size() == 0) begin
      err_other++;
      $display("Row %0d popped a word although none was due", row);
    end else begin
      check_word({name, " pop_data"}, exp_data_q.pop_front(), pop_data);
      check_flag({name, " pop_last"}, exp_last_q.pop_front(), pop_last);
      check_count({name, " pop_empty_count"}, exp_empty_q.pop_front(), pop_empty_count);
      check_meta({name, " pop_metadata"}, exp_meta_q.pop_front(), pop_metadata);
      // The closing word must also agree with the hand written table
      if (pop_last) begin
        check_count({name, " table empty count"}, row_empty[row], pop_empty_count);
      end
      word_num++;
    end
  endtask

  // Starts on a rising edge and returns on the edge where the flit transfers
  task automatic push_flit(input push_flit_t data, input logic last, input meta_t meta,
                           input logic final_flit);
    int    waited;
    string name;
    waited = 0;
    push_valid    <= 1'b1;
    push_data     <= data;
    push_last     <= last;
    push_metadata <= meta;
    pop_ready     <= pick_pop_ready();
    @(negedge clk);
    // Only a final flit can be held back, and only by the sink
    while (!push_ready && waited < wait_limit) begin
      @(posedge clk);
      pop_ready <= pick_pop_ready();
      @(negedge clk);
      waited++;
    end
    if (!push_ready) begin
      err_other++;
      timed_out = 1'b1;
      $display("Timeout in row %0d: the pop handshake held push_ready low for %0d cycles",
               row, wait_limit);
    end else begin
      name = $sformatf("row %0d word %0d", row, word_num);
      check_flag({name, " pop_valid"}, final_flit, pop_valid);
      if (pop_valid && pop_ready) begin
        compare_pop(name);
      end
    end
    @(posedge clk);
  endtask

  // One cycle with the source idle and the sink stalled
  // push_ready then stays high only if the index is back at the start of a word
  task automatic idle_cycle();
    push_valid <= 1'b0;
    push_last  <= 1'b0;
    pop_ready  <= 1'b0;
    @(negedge clk);
    check_flag($sformatf("row %0d idle pop_valid", row), 1'b0, pop_valid);
    check_flag($sformatf("row %0d idle push_ready", row), 1'b1, push_ready);
    @(posedge clk);
  endtask

  // Splits the packet into groups of four and queues one word per group
  task automatic send_packet(input int r);
    pop_word_t  word;
    push_flit_t flit;
    meta_t      meta;
    int         k;
    logic       last;
    logic       final_flit;
    row      = r;
    word_num = 0;
    stall_en = row_stall[r];
    word     = '0;
    for (int f = 0; f < row_len[r]; f++) begin
      k          = f % num_slices;
      last       = (f == row_len[r] - 1);
      final_flit = last || (k == num_slices - 1);
      // Metadata moves on by one from group to group
      meta = meta_t'(row_meta[r] + f / num_slices);
      flit = random_byte();
      if (k == 0) begin
        word = '0;
      end
      // Flit k of a group lands in slice k counted from the top
      word[pop_width - 1 - k * push_width -: push_width] = flit;
      if (final_flit) begin
        exp_data_q.push_back(word);
        exp_last_q.push_back(last);
        // Four slices minus the k + 1 flits of the closing group are empty
        exp_empty_q.push_back(last ? flit_id_t'(num_slices - (k + 1)) : flit_id_t'(0));
        exp_meta_q.push_back(meta);
      end
      push_flit(flit, last, meta, final_flit);
      if (timed_out) begin
        break;
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    lfsr_state = 16'd56;
    stall_en   = 1'b0;
    timed_out  = 1'b0;
    row        = 0;
    word_num   = 0;
    err_word   = 0;
    err_count  = 0;
    err_meta   = 0;
    err_flag   = 0;
    err_other  = 0;
    rst           <= 1'b1;
    push_valid    <= 1'b0;
    push_data     <= '0;
    push_last     <= 1'b0;
    push_metadata <= '0;
    pop_ready     <= 1'b1;
    load_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (3) idle_cycle();
    for (int r = 0; r < num_rows && !timed_out; r++) begin
      send_packet(r);
      if (!timed_out) begin
        idle_cycle();
      end
    end
    // Leftover entries mean words that never left the DUT
    if (!timed_out && exp_data_q.size() != 0) begin
      err_other++;
      $display("%0d expected words never appeared on the pop side", exp_data_q.size());
    end
    err_total = err_word + err_count + err_meta + err_flag + err_other;
    $display("Errors: %0d total (data %0d, empty count %0d, metadata %0d, flags %0d, other %0d)",
             err_total, err_word, err_count, err_meta, err_flag, err_other);
    if (err_total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/deser_pkg.sv
`default_nettype none

package deser_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Each push flit is one byte wide
  localparam int push_width = 8;

  // Four push flits make up one pop word
  localparam int num_slices = 4;

  // The pop word holds all slices side by side
  localparam int pop_width = push_width * num_slices;

  // Sideband metadata is carried next to the data and is never split
  localparam int meta_width = 3;

  // Wide enough to count from 0 to num_slices - 1
  localparam int flit_id_width = $clog2(num_slices);

  // Only the first num_slices - 1 slices are stored in lanes
  // The final slice is taken straight from the push side
  localparam int num_lanes = num_slices - 1;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  typedef logic [push_width-1:0] push_flit_t;

  typedef logic [pop_width-1:0] pop_word_t;

  typedef logic [meta_width-1:0] meta_t;

  // Position of a push flit inside the pop word it belongs to
  typedef logic [flit_id_width-1:0] flit_id_t;

  // Index of the flit that always closes a full word
  localparam flit_id_t last_flit_id = flit_id_t'(num_slices - 1);

endpackage

`default_nettype wire

// File: design/flit_counter.sv
`timescale 1ns/100ps
`default_nettype none

module flit_counter (
  input  wire logic              clk,
  input  wire logic              rst,

  // Push side handshake and packet end marker
  input  wire logic              push_valid,
  input  wire logic              push_last,
  output logic                   push_ready,

  // Pop side handshake
  input  wire logic              pop_ready,
  output logic                   pop_valid,

  // Transfer strobe and flit index shared with the lanes and the assembler
  output logic                   push_fire,
  output deser_pkg::flit_id_t    flit_id
);

  import deser_pkg::*;

  // ----------------------------------------
  // Final flit detection
  // ----------------------------------------

  // High when the flit on the push side closes the current pop word
  logic flit_final;

  // High on the edge where a complete word leaves on the pop side
  logic pop_fire;

  // A word closes either when all slices are used or when the
  // packet ends early with push_last
  assign flit_final = push_last || (flit_id == last_flit_id);

  // The final flit goes straight through to the pop side, so a word
  // is offered in the same cycle its final flit is valid
  assign pop_valid = push_valid && flit_final;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Flits that are not final only need room in a lane, and a lane
  // is always free for them
  // A final flit can only be taken when the sink accepts the word
  assign push_ready = !flit_final || pop_ready;

  assign push_fire = push_valid && push_ready;

  // A pop always coincides with the push of the final flit
  assign pop_fire = pop_valid && pop_ready;

  // ----------------------------------------
  // Flit index register
  // ----------------------------------------

  // The index starts over on the edge where the word leaves
  // Otherwise it steps by one on each accepted flit
  // It holds while the source is idle or while the sink stalls
  always_ff @(posedge clk) begin
    if (rst) begin
      flit_id <= '0;
    end else if (pop_fire) begin
      flit_id <= '0;
    end else if (push_fire) begin
      // Only flits below last_flit_id reach this branch, so the
      // index never wraps past the end of a word
      flit_id <= flit_id_t'(flit_id + 1'b1);
    end
  end

endmodule

`default_nettype wire

// File: design/flow_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

module flow_deserializer (
  input  wire logic                  clk,
  input  wire logic                  rst,

  // ----------------------------------------
  // Push side, one byte per flit
  // ----------------------------------------

  output logic                       push_ready,
  input  wire logic                  push_valid,
  input  wire deser_pkg::push_flit_t push_data,

  // Marks the final flit of a packet
  input  wire logic                  push_last,

  // Must stay constant across the flits of one pop word
  input  wire deser_pkg::meta_t      push_metadata,

  // ----------------------------------------
  // Pop side, four slices per word
  // ----------------------------------------

  input  wire logic                  pop_ready,
  output logic                       pop_valid,
  output deser_pkg::pop_word_t       pop_data,

  // Set on the word that closes the packet
  output logic                       pop_last,

  // Number of zero filled low slices on the closing word
  output deser_pkg::flit_id_t        pop_empty_count,

  output deser_pkg::meta_t           pop_metadata
);

  import deser_pkg::*;

  // Index of the live flit inside the word being built
  flit_id_t flit_id;

  // Accepted push flit
  logic push_fire;

  // One slice per lane, in pop word order
  push_flit_t lane_data [num_lanes];

  // ----------------------------------------
  // Flit index and handshake
  // ----------------------------------------

  flit_counter u_flit_counter (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_last  (push_last),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .push_fire  (push_fire),
    .flit_id    (flit_id)
  );

  // ----------------------------------------
  // Slice lanes
  // ----------------------------------------

  // One lane for every slice except the last one
  // The last slice is taken live from the push side by the assembler
  generate
    for (genvar i = 0; i < num_lanes; i++) begin : gen_lane
      slice_lane #(
        .lane_index (i)
      ) u_slice_lane (
        .clk       (clk),
        .rst       (rst),
        .push_fire (push_fire),
        .flit_id   (flit_id),
        .push_last (push_last),
        .push_data (push_data),
        .lane_data (lane_data[i])
      );
    end
  endgenerate

  // ----------------------------------------
  // Pop word assembly
  // ----------------------------------------

  // Purely combinational, so the word is ready in the cycle its
  // final flit shows up on the push side
  pop_assembler u_pop_assembler (
    .lane_data       (lane_data),
    .push_data       (push_data),
    .push_last       (push_last),
    .push_metadata   (push_metadata),
    .flit_id         (flit_id),
    .pop_data        (pop_data),
    .pop_last        (pop_last),
    .pop_empty_count (pop_empty_count),
    .pop_metadata    (pop_metadata)
  );

endmodule

`default_nettype wire

// File: design/pop_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module pop_assembler (
  // Stored or forwarded slices, lane i sits at slice position i
  input  wire deser_pkg::push_flit_t lane_data [deser_pkg::num_lanes],

  // Live push flit with its sideband
  input  wire deser_pkg::push_flit_t push_data,
  input  wire logic                  push_last,
  input  wire deser_pkg::meta_t      push_metadata,

  // Index of the live flit within the current word
  input  wire deser_pkg::flit_id_t   flit_id,

  // Assembled pop word and its sideband
  output deser_pkg::pop_word_t       pop_data,
  output logic                       pop_last,
  output deser_pkg::flit_id_t        pop_empty_count,
  output deser_pkg::meta_t           pop_metadata
);

  import deser_pkg::*;

  // ----------------------------------------
  // Slice placement
  // ----------------------------------------

  // Lowest bit of slice i in the pop word
  // Slice 0 is the most significant one since it arrives first
  function automatic int slice_lsb(input int idx);
    int lsb;
    lsb = (num_slices - 1 - idx) * push_width;
    return lsb;
  endfunction

  // The last slot has no lane behind it
  // It is only filled when the flit index reaches the end of the word
  push_flit_t final_slot;

  assign final_slot = (flit_id == last_flit_id) ? push_data : '0;

  // Each lane already decides between stored data, the live flit and
  // zero fill, so here the slices only need to be put side by side
  always_comb begin
    pop_data = '0;
    for (int i = 0; i < num_lanes; i++) begin
      pop_data[slice_lsb(i) +: push_width] = lane_data[i];
    end
    pop_data[slice_lsb(num_lanes) +: push_width] = final_slot;
  end

  // ----------------------------------------
  // Sideband
  // ----------------------------------------

  // The word closes its packet exactly when the live flit does
  assign pop_last = push_last;

  // Metadata comes from the final flit of the word, which is the one
  // on the push side while the word is offered
  assign pop_metadata = push_metadata;

  // On an early end the slices after the live flit are zero filled
  // The count tells the sink how many of them there are
  // Full words always report zero
  always_comb begin
    if (push_last) begin
      pop_empty_count = flit_id_t'(last_flit_id - flit_id);
    end else begin
      pop_empty_count = '0;
    end
  end

endmodule

`default_nettype wire

// File: design/slice_lane.sv
`timescale 1ns/100ps
`default_nettype none

module slice_lane #(
  // Slice position in the pop word, 0 is the most significant slice
  // Valid range is 0 to num_slices - 2
  parameter int lane_index = 0
) (
  input  wire logic                  clk,
  input  wire logic                  rst,

  // Transfer strobe and index from the flit counter
  input  wire logic                  push_fire,
  input  wire deser_pkg::flit_id_t   flit_id,

  // Live push flit
  input  wire logic                  push_last,
  input  wire deser_pkg::push_flit_t push_data,

  // Slice handed to the pop assembler
  output deser_pkg::push_flit_t      lane_data
);

  import deser_pkg::*;

  // ----------------------------------------
  // Lane decode
  // ----------------------------------------

  // The counter points at this lane
  logic lane_selected;

  // The packet ended before reaching this lane
  logic lane_unused;

  // Capture strobe for the stored slice
  logic load_en;

  // Slice held since the flit for this lane was accepted
  push_flit_t slice_q;

  assign lane_selected = (flit_id == flit_id_t'(lane_index));
  assign lane_unused   = (flit_id < flit_id_t'(lane_index));

  // A flit carrying push_last is final and leaves with the word in
  // the same cycle, so there is nothing to store for later
  assign load_en = push_fire && lane_selected && !push_last;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      slice_q <= '0;
    end else if (load_en) begin
      slice_q <= push_data;
    end
  end

  // ----------------------------------------
  // Output select
  // ----------------------------------------

  // On an early end the last live flit lands in this lane directly
  // Lanes past that flit are filled with zeros
  // In every other case the slice comes from storage
  always_comb begin
    if (push_last && lane_selected) begin
      lane_data = push_data;
    end else if (push_last && lane_unused) begin
      lane_data = '0;
    end else begin
      lane_data = slice_q;
    end
  end

endmodule

`default_nettype wire
